//--- Bender.yml
package:
  name: rv32_single_cycle

sources:
  - logic/rvPkg.sv
  - logic/control.sv
  - logic/alu.sv
  - logic/regFile.sv
  - logic/immExtend.sv
  - logic/fetchUnit.sv
  - logic/dataMemory.sv
  - logic/cpuTop.sv
  - target: test
    files:
      - tests/cpuTb.sv

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import rvPkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF
) (
    input  logic [DATA_WIDTH-1:0] srcA,
    input  logic [DATA_WIDTH-1:0] srcB,       // rd2 or immediate
    input  aluOpT                 aluControl,
    output logic [DATA_WIDTH-1:0] aluResult,
    output logic                  zero        // result is all zero
);

    logic [4:0] shamt;

    assign shamt = srcB[4:0]; // rv32 shift range

    always_comb begin
        case (aluControl)
            ALU_ADD:  aluResult = srcA + srcB;
            ALU_SUB:  aluResult = srcA - srcB;
            ALU_AND:  aluResult = srcA & srcB;
            ALU_OR:   aluResult = srcA | srcB;
            ALU_XOR:  aluResult = srcA ^ srcB;
            ALU_SLL:  aluResult = srcA << shamt;
            ALU_SRL,
            ALU_SRLI: aluResult = srcA >> shamt;           // logical
            ALU_SRA,
            ALU_SRAI: aluResult = $signed(srcA) >>> shamt; // sign fill
            default:  aluResult = '0;
        endcase
    end

    // equality test for branches after sub
    assign zero = (aluResult == '0);

endmodule

//--- logic/control.sv
`timescale 1ns/1ps

module control import rvPkg::*; (
    input  logic [6:0] op,                // opcode field
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  logic       zero,              // alu result was zero
    output logic       regWrite,
    output aluOpT      aluControl,
    output logic       aluSrc,            // 1 selects immExt as srcB
    output logic       memWrite,
    output pcSelT      pcSrc,
    output resultSelT  resultSrc,
    output immSelT     immSrc,
    output accessT     addressingControl  // load/store size
);

    always_comb begin
        // no-op unless an opcode below says otherwise
        regWrite          = 1'b0;
        aluControl        = ALU_ADD;
        aluSrc            = 1'b0;
        memWrite          = 1'b0;
        pcSrc             = PC_PLUS4;
        resultSrc         = RES_ALU;
        immSrc            = IMM_I;
        addressingControl = ACC_WORD;

        case (op)
            OP_R: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000:  aluControl = (funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
                    3'b001:  aluControl = ALU_SLL;
                    3'b100:  aluControl = ALU_XOR;
                    3'b101:  aluControl = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  aluControl = ALU_OR;
                    3'b111:  aluControl = ALU_AND;
                    default: regWrite   = 1'b0; // slt/sltu not supported
                endcase
            end

            OP_IMM: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                case (funct3)
                    3'b000:  aluControl = ALU_ADD;  // addi
                    3'b001:  aluControl = ALU_SLL;  // slli
                    3'b100:  aluControl = ALU_XOR;  // xori
                    3'b101:  aluControl = funct7[5] ? ALU_SRAI : ALU_SRLI;
                    3'b110:  aluControl = ALU_OR;   // ori
                    3'b111:  aluControl = ALU_AND;  // andi
                    default: regWrite   = 1'b0;     // slti/sltiu dropped
                endcase
            end

            OP_LOAD: begin
                regWrite          = 1'b1;
                aluSrc            = 1'b1;       // rs1 + offset
                resultSrc         = RES_MEM;
                addressingControl = accessT'(funct3);
            end

            OP_STORE: begin
                memWrite          = 1'b1;
                aluSrc            = 1'b1;
                immSrc            = IMM_S;
                addressingControl = accessT'(funct3);
            end

            OP_BRANCH: begin
                immSrc     = IMM_B;
                aluControl = ALU_SUB;           // zero means rs1 == rs2
                case (funct3)
                    3'b000:  pcSrc = zero ? PC_BRANCH : PC_PLUS4; // beq
                    3'b001:  pcSrc = zero ? PC_PLUS4 : PC_BRANCH; // bne
                    default: pcSrc = PC_PLUS4;  // other compares not decoded
                endcase
            end

            OP_JAL: begin
                regWrite  = 1'b1;
                immSrc    = IMM_J;
                resultSrc = RES_PC4;            // link
                pcSrc     = PC_BRANCH;          // pc + jump offset
            end

            OP_JALR: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;               // alu forms rs1 + imm
                resultSrc = RES_PC4;
                pcSrc     = PC_JALR;
            end

            default: ;                          // defaults above hold
        endcase
    end

endmodule

//--- logic/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import rvPkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_BYTES = 1024
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          imemWe,    // program loader
    input  logic [$clog2(IMEM_WORDS)-1:0] imemAddr,
    input  logic [31:0]                   imemData,
    input  logic [4:0]                    dbgAddr,   // register peek
    output logic [DATA_WIDTH-1:0]         pc,
    output logic [DATA_WIDTH-1:0]         dbgData
);

    logic [31:0]           instr;
    logic [DATA_WIDTH-1:0] pcPlus4;
    logic [6:0]            op;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [4:0]            rd;
    logic                  regWrite;
    aluOpT                 aluControl;
    logic                  aluSrc;
    logic                  memWrite;
    pcSelT                 pcSrc;
    resultSelT             resultSrc;
    immSelT                immSrc;
    accessT                addressingControl;
    logic [DATA_WIDTH-1:0] rd1;
    logic [DATA_WIDTH-1:0] rd2;
    logic [DATA_WIDTH-1:0] immExt;
    logic [DATA_WIDTH-1:0] srcB;
    logic [DATA_WIDTH-1:0] aluResult;
    logic                  zero;
    logic [DATA_WIDTH-1:0] readData;
    logic [DATA_WIDTH-1:0] result;
    logic                  regWe;
    logic                  memWe;

    // instruction fields
    assign op     = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // no architectural writes while held in reset
    assign regWe = regWrite & rstN;
    assign memWe = memWrite & rstN;

    assign srcB = aluSrc ? immExt : rd2;

    always_comb begin
        case (resultSrc)
            RES_MEM: result = readData;
            RES_PC4: result = pcPlus4;   // jal/jalr link
            default: result = aluResult;
        endcase
    end

    fetchUnit #(
        .DATA_WIDTH(DATA_WIDTH),
        .IMEM_WORDS(IMEM_WORDS)
    ) uFetch (
        .clk(clk),
        .rstN(rstN),
        .pcSrc(pcSrc),
        .immExt(immExt),
        .aluResult(aluResult),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .pc(pc),
        .pcPlus4(pcPlus4),
        .instr(instr)
    );

    control uControl (
        .op(op),
        .funct3(funct3),
        .funct7(funct7),
        .zero(zero),
        .regWrite(regWrite),
        .aluControl(aluControl),
        .aluSrc(aluSrc),
        .memWrite(memWrite),
        .pcSrc(pcSrc),
        .resultSrc(resultSrc),
        .immSrc(immSrc),
        .addressingControl(addressingControl)
    );

    immExtend #(.DATA_WIDTH(DATA_WIDTH)) uImm (
        .instr(instr),
        .immSrc(immSrc),
        .immExt(immExt)
    );

    regFile #(.DATA_WIDTH(DATA_WIDTH)) uRegs (
        .clk(clk),
        .we(regWe),
        .ra1(rs1),
        .ra2(rs2),
        .wa(rd),
        .wd(result),
        .dbgAddr(dbgAddr),
        .rd1(rd1),
        .rd2(rd2),
        .dbgData(dbgData)
    );

    alu #(.DATA_WIDTH(DATA_WIDTH)) uAlu (
        .srcA(rd1),
        .srcB(srcB),
        .aluControl(aluControl),
        .aluResult(aluResult),
        .zero(zero)
    );

    dataMemory #(
        .DATA_WIDTH(DATA_WIDTH),
        .DMEM_BYTES(DMEM_BYTES)
    ) uDmem (
        .clk(clk),
        .we(memWe),
        .addressingControl(addressingControl),
        .addr(aluResult),
        .wd(rd2),
        .rd(readData)
    );

endmodule

//--- logic/dataMemory.sv
`timescale 1ns/1ps

module dataMemory import rvPkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int DMEM_BYTES = 1024
) (
    input  logic                  clk,
    input  logic                  we,                 // store strobe
    input  accessT                addressingControl,  // size and sign
    input  logic [DATA_WIDTH-1:0] addr,               // byte address
    input  logic [DATA_WIDTH-1:0] wd,                 // rs2 data
    output logic [DATA_WIDTH-1:0] rd
);

    localparam int IDX_BITS = $clog2(DMEM_BYTES);

    logic [7:0]          mem [DMEM_BYTES];   // little endian bytes
    logic [IDX_BITS-1:0] a0;
    logic [IDX_BITS-1:0] a1;
    logic [IDX_BITS-1:0] a2;
    logic [IDX_BITS-1:0] a3;
    logic [7:0]          b0;
    logic [7:0]          b1;
    logic [7:0]          b2;
    logic [7:0]          b3;

    // byte lanes, wrap at the top of memory
    assign a0 = addr[IDX_BITS-1:0];
    assign a1 = a0 + IDX_BITS'(1);
    assign a2 = a0 + IDX_BITS'(2);
    assign a3 = a0 + IDX_BITS'(3);

    always_ff @(posedge clk) begin
        if (we) begin
            mem[a0] <= wd[7:0];              // every size writes lane 0
            if (addressingControl == ACC_HALF || addressingControl == ACC_WORD) begin
                mem[a1] <= wd[15:8];
            end
            if (addressingControl == ACC_WORD) begin
                mem[a2] <= wd[23:16];
                mem[a3] <= wd[31:24];
            end
        end
    end

    assign b0 = mem[a0];
    assign b1 = mem[a1];
    assign b2 = mem[a2];
    assign b3 = mem[a3];

    always_comb begin
        case (addressingControl)
            ACC_BYTE:  rd = DATA_WIDTH'($signed(b0));        // lb
            ACC_HALF:  rd = DATA_WIDTH'($signed({b1, b0}));  // lh
            ACC_BYTEU: rd = DATA_WIDTH'(b0);                 // lbu
            ACC_HALFU: rd = DATA_WIDTH'({b1, b0});           // lhu
            default:   rd = DATA_WIDTH'($signed({b3, b2, b1, b0})); // lw
        endcase
    end

endmodule

//--- logic/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import rvPkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int IMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  pcSelT                         pcSrc,
    input  logic [DATA_WIDTH-1:0]         immExt,     // branch/jal offset
    input  logic [DATA_WIDTH-1:0]         aluResult,  // jalr rs1 + imm
    input  logic                          imemWe,     // program load strobe
    input  logic [$clog2(IMEM_WORDS)-1:0] imemAddr,   // word index
    input  logic [31:0]                   imemData,
    output logic [DATA_WIDTH-1:0]         pc,
    output logic [DATA_WIDTH-1:0]         pcPlus4,
    output logic [31:0]                   instr
);

    localparam int IDX_BITS = $clog2(IMEM_WORDS);

    logic [31:0]           imem [IMEM_WORDS];
    logic [DATA_WIDTH-1:0] pcTarget;
    logic [DATA_WIDTH-1:0] jalrTarget;
    logic [DATA_WIDTH-1:0] pcNext;

    assign pcPlus4    = pc + DATA_WIDTH'(4);
    assign pcTarget   = pc + immExt;
    assign jalrTarget = aluResult & ~DATA_WIDTH'(1); // lsb cleared

    always_comb begin
        case (pcSrc)
            PC_BRANCH: pcNext = pcTarget;
            PC_JALR:   pcNext = jalrTarget;
            default:   pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // program loader writes while core held in reset
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign instr = imem[pc[IDX_BITS+1:2]]; // word aligned fetch

endmodule

//--- logic/immExtend.sv
`timescale 1ns/1ps

module immExtend import rvPkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF
) (
    input  logic [31:0]           instr,
    input  immSelT                immSrc,
    output logic [DATA_WIDTH-1:0] immExt  // sign extended
);

    // all forms take the sign from instr[31]
    always_comb begin
        case (immSrc)
            IMM_I: immExt = DATA_WIDTH'($signed(instr[31:20]));
            IMM_S: immExt = DATA_WIDTH'($signed({instr[31:25], instr[11:7]}));
            IMM_B: immExt = DATA_WIDTH'($signed({instr[31], instr[7],
                                                 instr[30:25], instr[11:8],
                                                 1'b0}));        // 13 bit offset
            IMM_J: immExt = DATA_WIDTH'($signed({instr[31], instr[19:12],
                                                 instr[20], instr[30:21],
                                                 1'b0}));        // 21 bit offset
            default: immExt = '0;
        endcase
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile import rvPkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF
) (
    input  logic                  clk,
    input  logic                  we,       // write enable
    input  logic [4:0]            ra1,      // rs1 index
    input  logic [4:0]            ra2,      // rs2 index
    input  logic [4:0]            wa,       // rd index
    input  logic [DATA_WIDTH-1:0] wd,
    input  logic [4:0]            dbgAddr,  // observation port
    output logic [DATA_WIDTH-1:0] rd1,
    output logic [DATA_WIDTH-1:0] rd2,
    output logic [DATA_WIDTH-1:0] dbgData
);

    logic [DATA_WIDTH-1:0] regs [32];

    // x0 never written
    always_ff @(posedge clk) begin
        if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    // async reads, x0 forced to zero
    assign rd1     = (ra1 == 5'd0)     ? '0 : regs[ra1];
    assign rd2     = (ra2 == 5'd0)     ? '0 : regs[ra2];
    assign dbgData = (dbgAddr == 5'd0) ? '0 : regs[dbgAddr];

endmodule

//--- logic/rvPkg.sv
package rvPkg;

    parameter int DATA_WIDTH_DEF = 32; // xlen of the rv32 subset

    // major opcodes, instr[6:0]
    localparam logic [6:0] OP_R      = 7'b0110011; // register-register alu
    localparam logic [6:0] OP_IMM    = 7'b0010011; // register-immediate alu
    localparam logic [6:0] OP_LOAD   = 7'b0000011; // lb lh lw lbu lhu
    localparam logic [6:0] OP_STORE  = 7'b0100011; // sb sh sw
    localparam logic [6:0] OP_BRANCH = 7'b1100011; // beq bne
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // alu operation, split right shifts keep separate codes for r and i forms
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001, // also used for branch compare
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b1000,
        ALU_SRA  = 4'b1011,
        ALU_SRAI = 4'b1100,
        ALU_SLL  = 4'b1101, // sll and slli share this code
        ALU_SRLI = 4'b1110
    } aluOpT;

    // immediate form picked by the extender
    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010, // implicit low zero
        IMM_J = 3'b011  // implicit low zero
    } immSelT;

    // next pc source
    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00,
        PC_BRANCH = 2'b01, // pc + imm, taken branch and jal
        PC_JALR   = 2'b10  // rs1 + imm, bit 0 cleared
    } pcSelT;

    // writeback source
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10 // link address
    } resultSelT;

    // load/store size, same bits as funct3
    typedef enum logic [2:0] {
        ACC_BYTE  = 3'b000,
        ACC_HALF  = 3'b001,
        ACC_WORD  = 3'b010,
        ACC_BYTEU = 3'b100,
        ACC_HALFU = 3'b101
    } accessT;

endpackage

//--- project.f
logic/rvPkg.sv
logic/control.sv
logic/alu.sv
logic/regFile.sv
logic/immExtend.sv
logic/fetchUnit.sv
logic/dataMemory.sv
logic/cpuTop.sv
tests/cpuTb.sv

//--- tests/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import rvPkg::*; ();

    localparam int DATA_WIDTH  = DATA_WIDTH_DEF;
    localparam int IMEM_WORDS  = 256;
    localparam int DMEM_BYTES  = 1024;
    localparam int IMEM_IDX    = $clog2(IMEM_WORDS);
    localparam int CYCLE_LIMIT = 600;  // six tests of at most 72 cycles, plus margin
    localparam int RUN_MARGIN  = 4;    // cycles past the last instruction
    localparam int MEM_BASE    = 256;  // data address of the memory test

    logic                  clk;
    logic                  rstN;
    logic                  imemWe;
    logic [IMEM_IDX-1:0]   imemAddr;
    logic [31:0]           imemData;
    logic [4:0]            dbgAddr;
    logic [DATA_WIDTH-1:0] pc;
    logic [DATA_WIDTH-1:0] dbgData;

    logic [31:0]           prog [64];      // program under construction
    int                    progLen;
    logic [DATA_WIDTH-1:0] expVal [32];    // expected register contents
    bit                    expSet [32];
    logic [7:0]            memModel [16];  // bytes from MEM_BASE upward
    logic [31:0]           lcgState;
    int                    cycleCount = 0;
    int                    checkCount = 0;
    int                    errorCount = 0;
    int                    testErrors = 0;
    int                    testCount  = 0;

    cpuTop #(
        .DATA_WIDTH(DATA_WIDTH),
        .IMEM_WORDS(IMEM_WORDS),
        .DMEM_BYTES(DMEM_BYTES)
    ) dut (
        .clk(clk),
        .rstN(rstN),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .dbgAddr(dbgAddr),
        .pc(pc),
        .dbgData(dbgData)
    );

    always #10 clk = ~clk;  // 20 ns period

    // watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("run stopped, cycle limit of %0d reached", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic logic [11:0] randImm12();
        logic [31:0] r;
        r = nextRand();
        return r[27:16];  // upper bits, low lcg bits are weak
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // instruction encoders, one per format
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // little endian byte model, extension by funct3
    function automatic logic [31:0] modelLoad(input int off, input logic [2:0] f3);
        logic [31:0] raw;
        raw = {memModel[off+3], memModel[off+2], memModel[off+1], memModel[off]};
        case (f3)
            3'b000:  return {{24{raw[7]}}, raw[7:0]};    // lb
            3'b001:  return {{16{raw[15]}}, raw[15:0]};  // lh
            3'b100:  return {24'd0, raw[7:0]};           // lbu
            3'b101:  return {16'd0, raw[15:0]};          // lhu
            default: return raw;                         // lw
        endcase
    endfunction

    task automatic modelStore(input int off, input logic [31:0] v, input int nBytes);
        for (int i = 0; i < nBytes; i++) begin
            memModel[off+i] = v[8*i +: 8];
        end
    endtask

    task automatic addInstr(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic expectReg(input int idx, input logic [DATA_WIDTH-1:0] val);
        expVal[idx] = val;
        expSet[idx] = 1'b1;
    endtask

    task automatic startProgram();
        progLen    = 0;
        testErrors = 0;
        for (int i = 0; i < 32; i++) begin
            expSet[i] = 1'b0;
        end
    endtask

    task automatic checkWord(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            testErrors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkPc(input logic [DATA_WIDTH-1:0] got, input logic [DATA_WIDTH-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            testErrors++;
            $display("Error: pc = %h, expected %h", got, exp);
        end
    endtask

    // writes the program with the core held in reset, at least 8 cycles
    task automatic loadProgram();
        @(posedge clk);
        rstN <= 1'b0;
        for (int i = 0; i < ((progLen > 8) ? progLen : 8); i++) begin
            @(posedge clk);
            imemWe   <= (i < progLen);
            imemAddr <= IMEM_IDX'(i);
            imemData <= prog[i];
        end
        @(posedge clk);
        imemWe <= 1'b0;
        @(negedge clk);
        checkPc(pc, '0);  // still in reset
    endtask

    task automatic addLoad(input logic [4:0] rd, input int off, input logic [2:0] f3);
        addInstr(encI(12'(off), 5'd1, f3, rd, OP_LOAD));
        expectReg(rd, modelLoad(off, f3));
    endtask

    // closes with jal x0, 0 and runs one cycle per instruction plus margin
    task automatic runProgram(input string name);
        addInstr(encJ(21'd0, 5'd0));
        loadProgram();
        @(posedge clk);
        rstN <= 1'b1;
        repeat (progLen + RUN_MARGIN) @(posedge clk);
        for (int r = 0; r < 32; r++) begin
            if (expSet[r]) begin
                @(posedge clk);
                dbgAddr <= 5'(r);
                @(negedge clk);  // combinational read settled
                checkWord($sformatf("x%0d", r), dbgData, expVal[r]);
            end
        end
        checkPc(pc, DATA_WIDTH'(4 * (progLen - 1)));  // parked on the self-loop
        testCount++;
        if (testErrors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, testErrors);
        end
    endtask

    task automatic testArith();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        startProgram();
        a = sext12(randImm12());
        b = sext12(randImm12());
        c = sext12(randImm12());
        addInstr(encI(a[11:0], 5'd0, 3'b000, 5'd1, OP_IMM));  // addi x1
        addInstr(encI(b[11:0], 5'd0, 3'b000, 5'd2, OP_IMM));  // addi x2
        addInstr(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));      // add
        addInstr(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));      // sub
        addInstr(encR(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));      // xor
        addInstr(encR(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));      // or
        addInstr(encR(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));      // and
        addInstr(encI(c[11:0], 5'd1, 3'b100, 5'd8, OP_IMM));  // xori
        addInstr(encI(c[11:0], 5'd1, 3'b110, 5'd9, OP_IMM));  // ori
        addInstr(encI(c[11:0], 5'd1, 3'b111, 5'd10, OP_IMM)); // andi
        expectReg(1, a);
        expectReg(2, b);
        expectReg(3, a + b);
        expectReg(4, a - b);
        expectReg(5, a ^ b);
        expectReg(6, a | b);
        expectReg(7, a & b);
        expectReg(8, a ^ c);
        expectReg(9, a | c);
        expectReg(10, a & c);
        runProgram("arith");
    endtask

    task automatic testShift();
        logic [11:0] imm;
        logic [31:0] v;
        logic [4:0]  amt;
        logic [4:0]  rs;
        logic [4:0]  rd;
        startProgram();
        imm     = randImm12();
        imm[11] = 1'b1;  // negative operand
        v       = sext12(imm);
        addInstr(encI(imm, 5'd0, 3'b000, 5'd1, OP_IMM));
        expectReg(1, v);
        for (int k = 0; k < 2; k++) begin
            imm = randImm12();
            amt = imm[4:0];
            rs  = 5'(2 + k);
            rd  = 5'(4 + 6 * k);
            addInstr(encI({7'd0, amt}, 5'd0, 3'b000, rs, OP_IMM));  // amount register
            addInstr(encR(7'h00, rs, 5'd1, 3'b001, rd));            // sll
            addInstr(encR(7'h00, rs, 5'd1, 3'b101, rd + 5'd1));     // srl
            addInstr(encR(7'h20, rs, 5'd1, 3'b101, rd + 5'd2));     // sra
            addInstr(encI({7'h00, amt}, 5'd1, 3'b001, rd + 5'd3, OP_IMM));  // slli
            addInstr(encI({7'h00, amt}, 5'd1, 3'b101, rd + 5'd4, OP_IMM));  // srli
            addInstr(encI({7'h20, amt}, 5'd1, 3'b101, rd + 5'd5, OP_IMM));  // srai
            expectReg(rs, {27'd0, amt});
            expectReg(rd, v << amt);
            expectReg(rd + 1, v >> amt);
            expectReg(rd + 2, $signed(v) >>> amt);
            expectReg(rd + 3, v << amt);
            expectReg(rd + 4, v >> amt);
            expectReg(rd + 5, $signed(v) >>> amt);
        end
        runProgram("shift");
    endtask

    task automatic testMemory();
        logic [31:0] w;
        startProgram();
        w = nextRand();
        addInstr(encI(12'(MEM_BASE), 5'd0, 3'b000, 5'd1, OP_IMM));  // base in x1
        // w assembled in x2 from 11, 11 and 10 bit pieces
        addInstr(encI({1'b0, w[31:21]}, 5'd0, 3'b000, 5'd2, OP_IMM));
        addInstr(encI(12'd11, 5'd2, 3'b001, 5'd2, OP_IMM));
        addInstr(encI({1'b0, w[20:10]}, 5'd2, 3'b110, 5'd2, OP_IMM));
        addInstr(encI(12'd10, 5'd2, 3'b001, 5'd2, OP_IMM));
        addInstr(encI({2'b0, w[9:0]}, 5'd2, 3'b110, 5'd2, OP_IMM));
        addInstr(encI(12'hfff, 5'd2, 3'b100, 5'd3, OP_IMM));  // x3 = ~w
        expectReg(2, w);
        expectReg(3, ~w);
        addInstr(encS(12'd0, 5'd2, 5'd1, 3'b010));  // sw
        modelStore(0, w, 4);
        addInstr(encS(12'd4, 5'd2, 5'd1, 3'b010));  // sw
        modelStore(4, w, 4);
        addInstr(encS(12'd4, 5'd3, 5'd1, 3'b001));  // sh over low half
        modelStore(4, ~w, 2);
        addInstr(encS(12'd7, 5'd3, 5'd1, 3'b000));  // sb top byte
        modelStore(7, ~w, 1);
        addLoad(5'd4, 0, 3'b010);
        addLoad(5'd5, 4, 3'b010);
        addLoad(5'd6, 2, 3'b001);
        addLoad(5'd7, 2, 3'b101);
        addLoad(5'd8, 3, 3'b000);
        addLoad(5'd9, 3, 3'b100);
        addLoad(5'd10, 4, 3'b001);
        addLoad(5'd11, 7, 3'b100);
        addLoad(5'd12, 7, 3'b000);
        addLoad(5'd13, 5, 3'b101);
        runProgram("memory");
    endtask

    task automatic testBranch();
        startProgram();
        addInstr(encI(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM));
        addInstr(encI(12'd5, 5'd0, 3'b000, 5'd2, OP_IMM));
        addInstr(encI(12'd7, 5'd0, 3'b000, 5'd3, OP_IMM));
        for (int r = 10; r < 16; r++) begin
            addInstr(encI(12'd0, 5'd0, 3'b000, 5'(r), OP_IMM));  // clear markers
        end
        addInstr(encB(13'd8, 5'd2, 5'd1, 3'b000));               // beq taken
        addInstr(encI(12'd1, 5'd0, 3'b000, 5'd10, OP_IMM));      // skipped
        addInstr(encI(12'd1, 5'd0, 3'b000, 5'd11, OP_IMM));      // landing
        addInstr(encB(13'd8, 5'd3, 5'd1, 3'b000));               // beq not taken
        addInstr(encI(12'd1, 5'd0, 3'b000, 5'd12, OP_IMM));
        addInstr(encB(13'd8, 5'd3, 5'd1, 3'b001));               // bne taken
        addInstr(encI(12'd1, 5'd0, 3'b000, 5'd13, OP_IMM));      // skipped
        addInstr(encI(12'd1, 5'd0, 3'b000, 5'd14, OP_IMM));      // landing
        addInstr(encB(13'd8, 5'd2, 5'd1, 3'b001));               // bne not taken
        addInstr(encI(12'd1, 5'd0, 3'b000, 5'd15, OP_IMM));
        expectReg(10, 0);
        expectReg(11, 1);
        expectReg(12, 1);
        expectReg(13, 0);
        expectReg(14, 1);
        expectReg(15, 1);
        runProgram("branch");
    endtask

    task automatic testJump();
        int jalIdx;
        int jalrIdx;
        int target;
        startProgram();
        for (int r = 10; r < 13; r++) begin
            addInstr(encI(12'd0, 5'd0, 3'b000, 5'(r), OP_IMM));  // clear markers
        end
        jalIdx = progLen;
        addInstr(encJ(21'd12, 5'd1));                            // jal x1, +12
        addInstr(encI(12'd1, 5'd0, 3'b000, 5'd10, OP_IMM));      // skipped
        addInstr(encI(12'd2, 5'd0, 3'b000, 5'd10, OP_IMM));      // skipped
        addInstr(encI(12'd3, 5'd0, 3'b000, 5'd11, OP_IMM));      // jal landing
        jalrIdx = progLen + 1;
        target  = 4 * (jalrIdx + 3) + 1;                         // odd, jalr clears bit 0
        addInstr(encI(12'(target), 5'd0, 3'b000, 5'd5, OP_IMM));
        addInstr(encI(12'd0, 5'd5, 3'b000, 5'd2, OP_JALR));      // jalr x2, 0(x5)
        addInstr(encI(12'd4, 5'd0, 3'b000, 5'd10, OP_IMM));      // skipped
        addInstr(encI(12'd5, 5'd0, 3'b000, 5'd10, OP_IMM));      // skipped
        addInstr(encI(12'd6, 5'd0, 3'b000, 5'd12, OP_IMM));      // jalr landing
        expectReg(1, 4 * jalIdx + 4);
        expectReg(2, 4 * jalrIdx + 4);
        expectReg(5, target);
        expectReg(10, 0);
        expectReg(11, 3);
        expectReg(12, 6);
        runProgram("jump");
    endtask

    task automatic testResetX0();
        logic [11:0] imm;
        logic [31:0] r;
        startProgram();
        imm = randImm12() | 12'h001;  // nonzero
        r   = nextRand();
        addInstr(encI(imm, 5'd0, 3'b000, 5'd5, OP_IMM));
        addInstr(encI(imm, 5'd0, 3'b000, 5'd6, OP_IMM));
        addInstr(encI(12'd123, 5'd0, 3'b000, 5'd0, OP_IMM));  // addi x0
        addInstr(encR(7'h00, 5'd5, 5'd5, 3'b000, 5'd0));      // add x0, x5, x5
        addInstr({r[31:12], 5'd5, 7'b1111111});               // unknown opcode, rd x5
        addInstr({r[31:12], 5'd6, 7'b0001011});               // custom-0, rd x6
        expectReg(0, 0);
        expectReg(5, sext12(imm));
        expectReg(6, sext12(imm));
        runProgram("reset_x0");
    endtask

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        dbgAddr  = '0;
        lcgState = 32'd57;
        testArith();
        testShift();
        testMemory();
        testBranch();
        testJump();
        testResetX0();
        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
